//--- common/cu_pkg.sv
// Shared types for the graph compute unit
// Byte addresses are 48 bits wide and vertex records are 8 bytes apart
// Read tags carry only the low 8 bits of the vertex index

`default_nettype none

package cu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths with a meaning
	//////////////////////////////////////////////////////////////////////

	typedef logic [47:0] addr_t;
	typedef logic [31:0] vertex_count_t;
	typedef logic [31:0] edge_count_t;
	typedef logic [15:0] degree_t;
	typedef logic [7:0]  tag_t;
	// Nonzero once the host has configured the unit
	typedef logic [63:0] config_t;

	// Stride between vertex records in memory
	localparam int VERTEX_BYTES = 8;

	//////////////////////////////////////////////////////////////////////
	// Grouped signals
	//////////////////////////////////////////////////////////////////////

	// Work descriptor from the host
	typedef struct packed {
		logic          valid;
		addr_t         vertex_base;
		vertex_count_t num_vertices;
		edge_count_t   num_edges;
	} wed_t;

	// Results back to the host
	typedef struct packed {
		vertex_count_t var1;
		edge_count_t   var2;
	} cu_return_t;

	// One read command toward memory
	typedef struct packed {
		logic  valid;
		tag_t  tag;
		addr_t address;
	} read_command_t;

	// One read response, a single vertex record
	typedef struct packed {
		logic    valid;
		tag_t    tag;
		degree_t degree;
	} read_response_t;

	// One vertex job handed to control
	typedef struct packed {
		logic          valid;
		vertex_count_t id;
		degree_t       degree;
	} vertex_job_t;

	// Control FSM
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DONE
	} cu_state_t;

endpackage

`default_nettype wire

//--- hdl/cu_control.sv
// Job control for the compute unit
// Inputs count only while the registered enable is high
// A descriptor is taken when it is valid and differs from the one held,
// and never during RUN, so the same job cannot be run twice in a row
// Done needs both sums to match the descriptor exactly

`timescale 1ns/1ns
`default_nettype none

module cu_control (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled_in,
	input  cu_pkg::wed_t          wed_request,
	input  cu_pkg::config_t       cu_configure,
	input  cu_pkg::vertex_job_t   vertex_job,
	input  logic                  issuer_busy,
	output logic                  start,
	output cu_pkg::addr_t         vertex_base,
	output cu_pkg::vertex_count_t num_vertices,
	output logic                  vertex_pop,
	output cu_pkg::cu_return_t    cu_return,
	output logic                  cu_done,
	output cu_pkg::config_t       cu_status
);

	logic                  enabled;
	cu_pkg::wed_t          wed_latched;
	cu_pkg::config_t       config_latched;
	cu_pkg::cu_state_t     state;
	cu_pkg::vertex_count_t vertex_counter;
	cu_pkg::edge_count_t   edge_counter;
	logic                  wed_new;
	logic                  cu_ready;
	logic                  sums_match;

	//////////////////////////////////////////////////////////////////////
	// Enable and input latching
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	// New job only between jobs
	assign wed_new = enabled && wed_request.valid && (wed_request != wed_latched) &&
		(state != cu_pkg::RUN);
	assign cu_ready = (|config_latched) && wed_latched.valid;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_latched    <= '0;
			config_latched <= '0;
		end else begin
			if (wed_new) begin
				wed_latched <= wed_request;
			end
			// Zero word keeps the last setting
			if (enabled && (|cu_configure)) begin
				config_latched <= cu_configure;
			end
		end
	end

	assign vertex_base  = wed_latched.vertex_base;
	assign num_vertices = wed_latched.num_vertices;

	//////////////////////////////////////////////////////////////////////
	// Job FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state   <= cu_pkg::IDLE;
			start   <= 1'b0;
			cu_done <= 1'b0;
		end else begin
			start <= 1'b0;
			if (wed_new) begin
				state   <= cu_pkg::IDLE;
				cu_done <= 1'b0;
			end else begin
				case (state)
					cu_pkg::IDLE: begin
						// Start pulse one cycle after both are held
						if (cu_ready) begin
							start <= 1'b1;
							state <= cu_pkg::RUN;
						end
					end
					cu_pkg::RUN: begin
						if (sums_match) begin
							state   <= cu_pkg::DONE;
							cu_done <= 1'b1;
						end
					end
					default: begin
						// DONE holds until the next descriptor
					end
				endcase
			end
		end
	end

	// Jobs consumed on the edge they are seen
	assign vertex_pop = (state == cu_pkg::RUN);

	//////////////////////////////////////////////////////////////////////
	// Vertex and edge sums
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_counter <= '0;
			edge_counter   <= '0;
			sums_match     <= 1'b0;
		end else begin
			if (wed_new) begin
				vertex_counter <= '0;
				edge_counter   <= '0;
			end else if (vertex_pop && vertex_job.valid) begin
				vertex_counter <= vertex_counter + 1'b1;
				edge_counter   <= edge_counter + cu_pkg::edge_count_t'(vertex_job.degree);
			end
			// One cycle from last count to match, one more to done
			sums_match <= !wed_new && (state == cu_pkg::RUN) && !start && !issuer_busy &&
				(vertex_counter == wed_latched.num_vertices) &&
				(edge_counter == wed_latched.num_edges);
		end
	end

	// Host side outputs follow the enable
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_return <= '0;
			cu_status <= '0;
		end else if (enabled) begin
			cu_return.var1 <= vertex_counter;
			cu_return.var2 <= edge_counter;
			cu_status      <= config_latched;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Queue must be drained before a job starts
	a_no_job_in_idle: assert property (@(posedge clock) disable iff (!rstn)
		(state == cu_pkg::IDLE) |-> !vertex_job.valid)
		else $error("vertex job valid while control is idle");

	a_vertex_bound: assert property (@(posedge clock) disable iff (!rstn)
		vertex_counter <= wed_latched.num_vertices)
		else $error("vertex count %0d above descriptor %0d", vertex_counter,
			wed_latched.num_vertices);

	// Jobs consumed in vertex order, ids compared in tag width
	a_job_order: assert property (@(posedge clock) disable iff (!rstn)
		(vertex_pop && vertex_job.valid) |->
		(cu_pkg::tag_t'(vertex_job.id) == cu_pkg::tag_t'(vertex_counter)))
		else $error("vertex job id %0d, expected %0d", vertex_job.id, vertex_counter);

endmodule

`default_nettype wire

//--- vertex_job/vertex_read_issuer.sv
// Walks the vertex array in index order, one read per cycle at most
// Each read takes one memory credit and one queue slot credit
// A start during a running walk restarts it from index zero

`timescale 1ns/1ns
`default_nettype none

module vertex_read_issuer #(
	parameter int MEM_CREDITS = 4,
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  start,
	input  cu_pkg::addr_t         vertex_base,
	input  cu_pkg::vertex_count_t num_vertices,
	input  logic                  cmd_credit,
	input  logic                  slot_credit,
	output cu_pkg::read_command_t read_command,
	output logic                  busy
);

	localparam int MCW = $clog2(MEM_CREDITS + 1);
	localparam int SCW = $clog2(QUEUE_DEPTH + 1);

	cu_pkg::addr_t         base;
	cu_pkg::vertex_count_t index;
	cu_pkg::vertex_count_t count;
	logic [MCW-1:0]        mem_credits;
	logic [SCW-1:0]        slot_credits;
	cu_pkg::addr_t         cur_base;
	cu_pkg::vertex_count_t cur_index;
	cu_pkg::vertex_count_t cur_count;
	logic                  issue;

	// Start bypass so the first read leaves the cycle after start
	assign cur_base  = start ? vertex_base : base;
	assign cur_index = start ? '0 : index;
	assign cur_count = start ? num_vertices : count;

	assign issue = (cur_index < cur_count) && (mem_credits != '0) && (slot_credits != '0);

	always_ff @(posedge clock) begin
		if (start) begin
			base <= vertex_base;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Walk and credit pools
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			index        <= '0;
			count        <= '0;
			mem_credits  <= MCW'(MEM_CREDITS);
			slot_credits <= SCW'(QUEUE_DEPTH);
			read_command <= '0;
		end else begin
			if (start) begin
				count <= num_vertices;
			end
			if (start || issue) begin
				index <= cur_index + cu_pkg::vertex_count_t'(issue);
			end
			mem_credits  <= mem_credits - MCW'(issue) + MCW'(cmd_credit);
			slot_credits <= slot_credits - SCW'(issue) + SCW'(slot_credit);
			// Address is base plus index times record size
			read_command.valid <= issue;
			if (issue) begin
				read_command.tag     <= cu_pkg::tag_t'(cur_index);
				read_command.address <= cur_base +
					cu_pkg::addr_t'(cur_index) * cu_pkg::addr_t'(cu_pkg::VERTEX_BYTES);
			end
		end
	end

	// Low once the last read is on the bus
	assign busy = (index < count);

	// Returned credits never exceed what was handed out
	a_credit_bound: assert property (@(posedge clock) disable iff (!rstn)
		(mem_credits <= MCW'(MEM_CREDITS)) && (slot_credits <= SCW'(QUEUE_DEPTH)))
		else $error("credit overflow mem %0d slot %0d", mem_credits, slot_credits);

endmodule

`default_nettype wire

//--- vertex_job/vertex_response_queue.sv
// Vertex record FIFO between memory and control
// Never refuses a beat, the issuer reserves a slot per read
// A zero tag out of sequence restarts the vertex id for a new job, so
// after a job of a multiple of 256 vertices the ids keep counting

`timescale 1ns/1ns
`default_nettype none

module vertex_response_queue #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  cu_pkg::read_response_t read_response,
	input  logic                   pop,
	output cu_pkg::vertex_job_t    vertex_job,
	output logic                   slot_credit
);

	localparam int AW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CW = $clog2(QUEUE_DEPTH + 1);
	localparam logic [AW-1:0] LAST = AW'(QUEUE_DEPTH - 1);

	cu_pkg::degree_t       degree_mem [QUEUE_DEPTH];
	cu_pkg::vertex_count_t id_mem [QUEUE_DEPTH];
	logic [AW-1:0]         wr_ptr;
	logic [AW-1:0]         rd_ptr;
	logic [CW-1:0]         fill;
	cu_pkg::vertex_count_t wr_id;
	cu_pkg::vertex_count_t rec_id;
	logic                  new_job;
	logic                  push;
	logic                  do_pop;

	// Id of the incoming record
	assign new_job = (read_response.tag == '0) && (cu_pkg::tag_t'(wr_id) != '0);
	assign rec_id  = new_job ? '0 : wr_id;

	assign push   = read_response.valid;
	assign do_pop = pop && (fill != '0);

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (push) begin
			degree_mem[wr_ptr] <= read_response.degree;
			id_mem[wr_ptr]     <= rec_id;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pointers, fill level and slot return
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			fill        <= '0;
			wr_id       <= '0;
			slot_credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
				wr_id  <= rec_id + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			end
			fill <= fill + CW'(push) - CW'(do_pop);
			// One slot back per pop
			slot_credit <= do_pop;
		end
	end

	// Head record, visible the edge after its write
	assign vertex_job.valid  = (fill != '0);
	assign vertex_job.id     = id_mem[rd_ptr];
	assign vertex_job.degree = degree_mem[rd_ptr];

	// In order answers from memory
	a_tag_order: assert property (@(posedge clock) disable iff (!rstn)
		read_response.valid |-> (read_response.tag == cu_pkg::tag_t'(rec_id)))
		else $error("tag %0h out of order, expected %0h", read_response.tag,
			cu_pkg::tag_t'(rec_id));

	a_no_overflow: assert property (@(posedge clock) disable iff (!rstn)
		read_response.valid |-> (fill != CW'(QUEUE_DEPTH)))
		else $error("response written into a full queue");

endmodule

`default_nettype wire

//--- hdl/cu_top.sv
// Graph compute unit top, one job at a time
// Memory must answer reads in order, one record per beat
// MEM_CREDITS is the number of reads memory accepts in flight

`timescale 1ns/1ns
`default_nettype none

module cu_top #(
	parameter int MEM_CREDITS = 4,
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled_in,
	input  cu_pkg::wed_t           wed_request,
	input  cu_pkg::config_t        cu_configure,
	input  cu_pkg::read_response_t read_response,
	input  logic                   cmd_credit,
	output cu_pkg::read_command_t  read_command,
	output cu_pkg::cu_return_t     cu_return,
	output logic                   cu_done,
	output cu_pkg::config_t        cu_status
);

	logic                  start;
	cu_pkg::addr_t         vertex_base;
	cu_pkg::vertex_count_t num_vertices;
	logic                  issuer_busy;
	logic                  slot_credit;
	logic                  vertex_pop;
	cu_pkg::vertex_job_t   vertex_job;

	//////////////////////////////////////////////////////////////////////
	// Job control
	//////////////////////////////////////////////////////////////////////

	cu_control u_control (
		.clock        (clock),
		.rstn         (rstn),
		.enabled_in   (enabled_in),
		.wed_request  (wed_request),
		.cu_configure (cu_configure),
		.vertex_job   (vertex_job),
		.issuer_busy  (issuer_busy),
		.start        (start),
		.vertex_base  (vertex_base),
		.num_vertices (num_vertices),
		.vertex_pop   (vertex_pop),
		.cu_return    (cu_return),
		.cu_done      (cu_done),
		.cu_status    (cu_status)
	);

	//////////////////////////////////////////////////////////////////////
	// Read side, two credit loops
	//////////////////////////////////////////////////////////////////////

	vertex_read_issuer #(
		.MEM_CREDITS (MEM_CREDITS),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_issuer (
		.clock        (clock),
		.rstn         (rstn),
		.start        (start),
		.vertex_base  (vertex_base),
		.num_vertices (num_vertices),
		.cmd_credit   (cmd_credit),
		.slot_credit  (slot_credit),
		.read_command (read_command),
		.busy         (issuer_busy)
	);

	vertex_response_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_queue (
		.clock         (clock),
		.rstn          (rstn),
		.read_response (read_response),
		.pop           (vertex_pop),
		.vertex_job    (vertex_job),
		.slot_credit   (slot_credit)
	);

endmodule

`default_nettype wire

//--- verification/mem_model.sv
// Testbench memory for vertex reads, answers strictly in command order
// Degree table of TABLE_SIZE entries, indexed by record number with wrap
// Credits go back one per cycle after the answer, with random hold stretches

`timescale 1ns/1ns
`default_nettype none

module mem_model #(
	parameter int TABLE_SIZE = 64
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  cu_pkg::read_command_t  read_command,
	output cu_pkg::read_response_t read_response,
	output logic                   cmd_credit
);

	cu_pkg::degree_t       degree_table [TABLE_SIZE];
	cu_pkg::read_command_t pending [$];
	cu_pkg::read_command_t head;
	int                    seed;
	int                    delay;
	int                    credits_owed;
	int                    hold;

	// Record number wraps over the table
	function automatic int slot_of(input cu_pkg::addr_t address);
		cu_pkg::addr_t record;
		record = address / cu_pkg::addr_t'(cu_pkg::VERTEX_BYTES);
		return int'(record % cu_pkg::addr_t'(TABLE_SIZE));
	endfunction

	initial begin
		seed = 32'h8945_0e78;
		for (int i = 0; i < TABLE_SIZE; i++) begin
			degree_table[i] = cu_pkg::degree_t'($random(seed) & 32'h3ff);
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Answers and credits, both on the falling edge
	////////////////////////////////////////////////////////////////////////

	always @(negedge clock or negedge rstn) begin
		if (!rstn) begin
			pending.delete();
			read_response <= '0;
			cmd_credit    <= 1'b0;
			delay         = 0;
			credits_owed  = 0;
			hold          = 0;
		end else begin
			read_response <= '0;
			cmd_credit    <= 1'b0;
			// Only credits for answers already sent
			if (hold > 0) begin
				hold = hold - 1;
			end else if (credits_owed > 0) begin
				cmd_credit   <= 1'b1;
				credits_owed = credits_owed - 1;
				if (($random(seed) & 7) == 0) begin
					hold = 6;
				end
			end
			if (read_command.valid) begin
				pending.push_back(read_command);
			end
			if (pending.size() != 0) begin
				if (delay == 0) begin
					head = pending.pop_front();
					read_response.valid  <= 1'b1;
					read_response.tag    <= head.tag;
					read_response.degree <= degree_table[slot_of(head.address)];
					credits_owed         = credits_owed + 1;
					// Delay before the next answer, 0 to 5 cycles
					delay = int'($unsigned($random(seed)) % 6);
				end else begin
					delay = delay - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/cu_tb.sv
// Testbench for the graph compute unit
// Two jobs with a disabled stretch between them
// Expected sums come from the degree table in the memory model

`timescale 1ns/1ns
`default_nettype none

module cu_tb;

	localparam int MEM_CREDITS = 4;
	localparam int QUEUE_DEPTH = 8;
	localparam int TABLE_SIZE  = 64;
	localparam int WAIT_LIMIT  = 2000;
	localparam cu_pkg::config_t CFG_WORD = 64'h0000_0001_c0de_0042;
	localparam cu_pkg::config_t ALT_WORD = 64'h0000_0002_beef_0007;

	logic                   clock;
	logic                   rstn;
	logic                   enabled_in;
	cu_pkg::wed_t           wed_request;
	cu_pkg::config_t        cu_configure;
	cu_pkg::read_response_t read_response;
	logic                   cmd_credit;
	cu_pkg::read_command_t  read_command;
	cu_pkg::cu_return_t     cu_return;
	logic                   cu_done;
	cu_pkg::config_t        cu_status;

	int                  checks = 0;
	int                  errors = 0;
	int                  timeouts = 0;
	int                  issued_count = 0;
	int                  credit_count = 0;
	int                  job_first_cmd = 0;
	int                  hold_count;
	cu_pkg::addr_t       exp_base = '0;
	cu_pkg::edge_count_t exp_edges;

	cu_top #(
		.MEM_CREDITS (MEM_CREDITS),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) uut (
		.clock         (clock),
		.rstn          (rstn),
		.enabled_in    (enabled_in),
		.wed_request   (wed_request),
		.cu_configure  (cu_configure),
		.read_response (read_response),
		.cmd_credit    (cmd_credit),
		.read_command  (read_command),
		.cu_return     (cu_return),
		.cu_done       (cu_done),
		.cu_status     (cu_status)
	);

	mem_model #(
		.TABLE_SIZE (TABLE_SIZE)
	) mem (
		.clock         (clock),
		.rstn          (rstn),
		.read_command  (read_command),
		.read_response (read_response),
		.cmd_credit    (cmd_credit)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic wait_done(input logic level, input string name);
		int cycles;
		cycles = 0;
		while (cu_done !== level && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		if (cu_done !== level) begin
			timeouts++;
			$display("Timeout in %s, cu_done did not go to %0b", name, level);
		end
	endtask

	// Descriptor and expected edge sum for a job of count records at base
	task automatic load_job(input cu_pkg::addr_t base, input int count);
		cu_pkg::edge_count_t sum;
		int first_slot;
		sum = '0;
		first_slot = int'(base / cu_pkg::addr_t'(cu_pkg::VERTEX_BYTES));
		for (int i = 0; i < count; i++) begin
			sum = sum + cu_pkg::edge_count_t'(mem.degree_table[(first_slot + i) % TABLE_SIZE]);
		end
		exp_base                 = base;
		exp_edges                = sum;
		job_first_cmd            = issued_count;
		wed_request.valid        = 1'b1;
		wed_request.vertex_base  = base;
		wed_request.num_vertices = cu_pkg::vertex_count_t'(count);
		wed_request.num_edges    = sum;
	endtask

	task automatic check_job(input string name, input int count);
		check_value({name, " vertex count"}, 64'(count), 64'(cu_return.var1));
		check_value({name, " edge sum"}, 64'(exp_edges), 64'(cu_return.var2));
		check_value({name, " status"}, CFG_WORD, cu_status);
		check_value({name, " command count"}, 64'(count), 64'(issued_count - job_first_cmd));
	endtask

	////////////////////////////////////////////////////////////////////////
	// Bus monitors
	////////////////////////////////////////////////////////////////////////

	// Command seen mid cycle, address and tag must follow the index
	always @(negedge clock) begin
		if (rstn && read_command.valid) begin
			check_value("address order", exp_base + cu_pkg::addr_t'(issued_count - job_first_cmd)
				* cu_pkg::addr_t'(cu_pkg::VERTEX_BYTES), read_command.address);
			check_value("command tag", 64'((issued_count - job_first_cmd) % 256),
				64'(read_command.tag));
			issued_count <= issued_count + 1;
		end
	end

	always @(posedge clock) begin
		if (rstn && cmd_credit) begin
			credit_count <= credit_count + 1;
		end
	end

	credit_limit: assert property (@(posedge clock) disable iff (!rstn)
		(issued_count - credit_count) <= MEM_CREDITS)
		else begin
			errors++;
			$display("[FAIL] credit limit: expected at most %0d, actual %0d", MEM_CREDITS,
				$sampled(issued_count) - $sampled(credit_count));
		end

	quiet_after_done: assert property (@(posedge clock) disable iff (!rstn)
		cu_done |-> !read_command.valid)
		else begin
			errors++;
			$display("[FAIL] quiet after done: expected valid 0, actual 1");
		end

	////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////

	initial begin
		rstn         = 1'b0;
		enabled_in   = 1'b0;
		wed_request  = '0;
		cu_configure = '0;
		repeat (3) @(negedge clock);
		rstn = 1'b1;
		repeat (2) @(negedge clock);
		check_value("reset cu_done", 64'(0), 64'(cu_done));
		check_value("reset cu_status", 64'(0), cu_status);
		check_value("reset cu_return", 64'(0), cu_return);
		check_value("reset command valid", 64'(0), 64'(read_command.valid));

		// First job, 20 records
		enabled_in   = 1'b1;
		cu_configure = CFG_WORD;
		load_job(48'h0000_0000_1000, 20);
		wait_done(1'b1, "full job");
		check_job("full job", 20);

		// Zero word keeps the held setting
		cu_configure = '0;
		repeat (4) @(negedge clock);
		check_value("zero configure hold", CFG_WORD, cu_status);

		// Disabled, inputs move but nothing may follow
		enabled_in = 1'b0;
		@(negedge clock);
		hold_count   = issued_count;
		cu_configure = ALT_WORD;
		load_job(48'h0000_0000_1100, 7);
		repeat (6) @(negedge clock);
		check_value("disabled status hold", CFG_WORD, cu_status);
		check_value("disabled done hold", 64'(1), 64'(cu_done));
		check_value("disabled no commands", 64'(hold_count), 64'(issued_count));

		// Second job starts once enabled again
		cu_configure = '0;
		enabled_in   = 1'b1;
		wait_done(1'b0, "second job clear");
		wait_done(1'b1, "second job");
		check_job("second job", 7);

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
common/cu_pkg.sv
hdl/cu_control.sv
vertex_job/vertex_read_issuer.sv
vertex_job/vertex_response_queue.sv
hdl/cu_top.sv
verification/mem_model.sv
verification/cu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the compute unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module cu_tb -Mdir "$BUILD_DIR" -f sources.f

"./$BUILD_DIR/Vcu_tb" | tee "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
	echo "Simulation reported failure, see $LOG"
	exit 1
fi

echo "Simulation finished without failure"
